//--- dv/tb_mcoc.sv
`timescale 1ns/10ps

module tb_mcoc;

	logic                        clk;
	logic                        rst_n_i;
	logic                        bus_stb_i;
	logic                        bus_wr_i;
	logic [mcoc_pkg::ADDR_W-1:0] bus_addr_i;
	logic [mcoc_pkg::DATA_W-1:0] bus_wdata_i;
	logic                        rd_valid_o;
	logic [mcoc_pkg::DATA_W-1:0] rd_data_o;
	logic [15:0]                 port_pins_i;
	logic [7:0]                  port_out_o;
	logic [7:0]                  port_oe_o;
	logic [1:0]                  ext_int_i;	// int1, int0
	logic                        tim0_pwma_o;
	logic                        tim0_pwmb_o;
	logic                        tim1_pwma_o;
	logic                        tim1_pwmb_o;
	logic                        irq_o;

	int mismatch_cnt;
	int timeout_cnt;
	int seed;

	mcoc_top mcoc_top_i (.*);

	always #20 clk = ~clk;	// 40 ns period

	function automatic logic [15:0] addr_of(input logic [11:0] blk, input logic [3:0] ofs);
		return {blk, ofs};
	endfunction

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);	// Non negative
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
		@(posedge clk);
		bus_stb_i   <= 1'b1;
		bus_wr_i    <= 1'b1;
		bus_addr_i  <= addr;
		bus_wdata_i <= data;
		@(posedge clk);
		bus_stb_i   <= 1'b0;
		bus_wr_i    <= 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
		int cyc;
		@(posedge clk);
		bus_stb_i  <= 1'b1;
		bus_wr_i   <= 1'b0;
		bus_addr_i <= addr;
		for (cyc = 1; cyc <= 16; cyc++) begin
			@(posedge clk);
			bus_stb_i <= 1'b0;	// Single cycle strobe
			@(negedge clk);
			if (rd_valid_o) break;
		end
		if (cyc > 16) begin
			$display("Timeout: no read response for address 0x%04h", addr);
			timeout_cnt++;
			data = '0;
		end else begin
			check("rd_latency", cyc, 2);	// Cycles from strobe
			data = rd_data_o;
		end
	endtask

	task automatic read_expect(input string name, input logic [15:0] addr,
			input logic [15:0] exp);
		logic [15:0] rd;
		bus_read(addr, rd);
		check(name, rd, exp);
	endtask

	// Two strobes on consecutive cycles
	task automatic read_pair(input logic [15:0] a0, input logic [15:0] a1,
			input logic [15:0] e0, input logic [15:0] e1);
		int          n;
		int          at [2];
		logic [15:0] got [2];
		n = 0;
		@(posedge clk);
		bus_stb_i  <= 1'b1;
		bus_wr_i   <= 1'b0;
		bus_addr_i <= a0;
		for (int cyc = 1; cyc <= 10 && n < 2; cyc++) begin
			@(posedge clk);
			if (cyc == 1) bus_addr_i <= a1;
			else bus_stb_i <= 1'b0;
			@(negedge clk);
			if (rd_valid_o) begin
				got[n] = rd_data_o;
				at[n]  = cyc;
				n++;
			end
		end
		if (n < 2) begin
			$display("Timeout: only %0d of two back-to-back reads answered", n);
			timeout_cnt++;
		end else begin
			check("rd_latency_first", at[0], 2);
			check("rd_latency_second", at[1] - 1, 2);	// Strobed one cycle later
			check("rd_data_first", got[0], e0);
			check("rd_data_second", got[1], e1);
		end
	endtask

	// Reads COUNT on every cycle until a zero comes back
	task automatic wait_count_zero(input logic [11:0] blk);
		int cyc;
		@(posedge clk);
		bus_stb_i  <= 1'b1;
		bus_wr_i   <= 1'b0;
		bus_addr_i <= addr_of(blk, mcoc_pkg::TIM_COUNT);
		for (cyc = 0; cyc < 200; cyc++) begin
			@(negedge clk);
			if (rd_valid_o && rd_data_o == '0) break;
			@(posedge clk);
		end
		@(posedge clk);
		bus_stb_i <= 1'b0;
		if (cyc == 200) begin
			$display("Timeout: timer COUNT never read back as zero");
			timeout_cnt++;
		end
	endtask

	task automatic wait_irq(input int max_cyc);
		int cyc;
		for (cyc = 0; cyc < max_cyc; cyc++) begin
			@(negedge clk);
			if (irq_o) break;
		end
		if (cyc == max_cyc) begin
			$display("Timeout: irq_o did not rise within %0d cycles", max_cyc);
			timeout_cnt++;
		end
	endtask

	task automatic reset_values();
		check("rd_valid_o", rd_valid_o, 0);
		check("irq_o", irq_o, 0);
		check("port_out_o", port_out_o, 0);
		check("port_oe_o", port_oe_o, 0);
		check("pwm_outputs", {tim0_pwma_o, tim0_pwmb_o, tim1_pwma_o, tim1_pwmb_o}, 0);
	endtask

	task automatic id_and_decode();
		read_expect("id_code", addr_of(mcoc_pkg::BLK_IDRG, 4'h0), 16'h1150);
		read_expect("id_version", addr_of(mcoc_pkg::BLK_IDRG, 4'h1), 16'h0148);
		read_expect("id_edition", addr_of(mcoc_pkg::BLK_IDRG, 4'h2), 16'h5457);	// "TW"
		read_expect("id_unused", addr_of(mcoc_pkg::BLK_IDRG, 4'h3), 16'h0000);
		read_expect("unmapped", 16'h6000, 16'h0000);
		read_pair(addr_of(mcoc_pkg::BLK_IDRG, 4'h0), addr_of(mcoc_pkg::BLK_IDRG, 4'h1),
			16'h1150, 16'h0148);
	endtask

	task automatic port_io();
		logic [7:0]  d;
		logic [7:0]  e;
		logic [7:0]  s;
		logic [7:0]  exp;
		logic [15:0] pins;
		d    = 8'(rand_below(256));
		e    = 8'(rand_below(256));
		s    = 8'(rand_below(256));
		pins = 16'(rand_below(65536));
		bus_write(addr_of(mcoc_pkg::BLK_PORT, mcoc_pkg::PORT_DATA), {8'h00, d});
		bus_write(addr_of(mcoc_pkg::BLK_PORT, mcoc_pkg::PORT_ENB), {8'h00, e});
		read_expect("port_data", addr_of(mcoc_pkg::BLK_PORT, mcoc_pkg::PORT_DATA), {8'h00, d});
		read_expect("port_enb", addr_of(mcoc_pkg::BLK_PORT, mcoc_pkg::PORT_ENB), {8'h00, e});
		check("port_out_o", port_out_o, d);
		check("port_oe_o", port_oe_o, e);
		@(posedge clk);
		port_pins_i <= pins;
		bus_write(addr_of(mcoc_pkg::BLK_PORT, mcoc_pkg::PORT_SEL), {8'h00, s});
		for (int k = 0; k < 8; k++) begin
			exp[k] = s[k] ? pins[k] : pins[k+8];	// Low pin when selected
		end
		read_expect("port_pin", addr_of(mcoc_pkg::BLK_PORT, mcoc_pkg::PORT_PIN), {8'h00, exp});
	endtask

	task automatic timer_duty(input int t);
		logic [11:0] blk;
		int          p;
		int          ca;
		int          cb;
		int          na;
		int          nb;
		blk = (t == 0) ? mcoc_pkg::BLK_TIM0 : mcoc_pkg::BLK_TIM1;
		p   = rand_below(64);
		ca  = rand_below(p + 2);	// Up to P+1 for full duty
		cb  = rand_below(p + 2);
		na  = 0;
		nb  = 0;
		bus_write(addr_of(blk, mcoc_pkg::TIM_PERIOD), 16'(p));
		bus_write(addr_of(blk, mcoc_pkg::TIM_CMPA), 16'(ca));
		bus_write(addr_of(blk, mcoc_pkg::TIM_CMPB), 16'(cb));
		bus_write(addr_of(blk, mcoc_pkg::TIM_CTRL), 16'h0001);
		wait_count_zero(blk);
		for (int i = 0; i < (p + 1) * 4; i++) begin	// Four whole periods
			@(negedge clk);
			if ((t == 0) ? tim0_pwma_o : tim1_pwma_o) na++;
			if ((t == 0) ? tim0_pwmb_o : tim1_pwmb_o) nb++;
		end
		check($sformatf("tim%0d_pwma_high_cycles", t), na, ca * 4);
		check($sformatf("tim%0d_pwmb_high_cycles", t), nb, cb * 4);
		bus_write(addr_of(blk, mcoc_pkg::TIM_CTRL), 16'h0000);
	endtask

	task automatic timer_irq();
		logic [15:0] rd;
		int          hi;
		hi = 0;
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_MASK), 16'h0004);	// tim0 ovf
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), 16'h00FF);	// Old events
		bus_write(addr_of(mcoc_pkg::BLK_TIM0, mcoc_pkg::TIM_PERIOD), 16'd9);
		bus_write(addr_of(mcoc_pkg::BLK_TIM0, mcoc_pkg::TIM_CMPA), 16'd3);
		bus_write(addr_of(mcoc_pkg::BLK_TIM0, mcoc_pkg::TIM_CMPB), 16'd5);
		bus_write(addr_of(mcoc_pkg::BLK_TIM0, mcoc_pkg::TIM_CTRL), 16'h0001);
		wait_irq(100);
		bus_read(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), rd);
		check("intc_pend_tim0_ovf", rd[2], 1'b1);
		bus_write(addr_of(mcoc_pkg::BLK_TIM0, mcoc_pkg::TIM_CTRL), 16'h0000);
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), 16'h00FF);
		read_expect("intc_pend_cleared", addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), 0);
		check("irq_o", irq_o, 0);
		// All tim0 sources masked off
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_MASK), 16'h00E3);
		bus_write(addr_of(mcoc_pkg::BLK_TIM0, mcoc_pkg::TIM_CTRL), 16'h0001);
		for (int i = 0; i < 40; i++) begin
			@(negedge clk);
			if (irq_o) hi++;
		end
		check("irq_o_masked_high_cycles", hi, 0);
		bus_read(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), rd);
		check("intc_pend_tim0_events", rd[4:2], 3'b111);
		bus_write(addr_of(mcoc_pkg::BLK_TIM0, mcoc_pkg::TIM_CTRL), 16'h0000);
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), 16'h00FF);
	endtask

	task automatic ext_irq_vector();
		logic [15:0] rd;
		int          cyc;
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_MASK), 16'h0003);
		@(posedge clk);
		ext_int_i <= 2'b10;	// int1 first
		wait_irq(20);
		@(posedge clk);
		ext_int_i <= 2'b11;
		for (cyc = 0; cyc < 10; cyc++) begin
			bus_read(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), rd);
			if (rd[0]) break;
		end
		if (cyc == 10) begin
			$display("Timeout: int0 never became pending");
			timeout_cnt++;
		end
		check("intc_pend", rd, 16'h0003);
		read_expect("intc_vec", addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_VEC), 16'h0000);
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), 16'h0001);
		read_expect("intc_vec", addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_VEC), 16'h0001);
		bus_write(addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_PEND), 16'h00FF);
		read_expect("intc_vec", addr_of(mcoc_pkg::BLK_INTC, mcoc_pkg::INTC_VEC), 16'h0008);
		check("irq_o", irq_o, 0);
		@(posedge clk);
		ext_int_i <= 2'b00;
	endtask

	initial begin
		clk          = 1'b0;
		rst_n_i      = 1'b0;
		bus_stb_i    = 1'b0;
		bus_wr_i     = 1'b0;
		bus_addr_i   = '0;
		bus_wdata_i  = '0;
		port_pins_i  = '0;
		ext_int_i    = '0;
		seed         = 31915;
		mismatch_cnt = 0;
		timeout_cnt  = 0;
		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		reset_values();
		id_and_decode();
		port_io();
		timer_duty(0);
		timer_duty(1);
		timer_irq();
		ext_irq_vector();
		$display("Checks done with %0d mismatches and %0d timeouts", mismatch_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && timeout_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- logic/bus_ctrl.sv
`timescale 1ns/10ps

module bus_ctrl (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        bus_stb_i,	// One cycle per request
	input  logic                        bus_wr_i,	// High for write
	input  logic [mcoc_pkg::ADDR_W-1:0] bus_addr_i,
	input  logic [mcoc_pkg::DATA_W-1:0] bus_wdata_i,
	input  logic [mcoc_pkg::DATA_W-1:0] rd_port_i,	// Zero unless selected
	input  logic [mcoc_pkg::DATA_W-1:0] rd_tim0_i,
	input  logic [mcoc_pkg::DATA_W-1:0] rd_tim1_i,
	input  logic [mcoc_pkg::DATA_W-1:0] rd_intc_i,
	output mcoc_pkg::bus_req_t          req_o,	// Broadcast to all blocks
	output mcoc_pkg::blk_sel_t          sel_o,
	output logic                        rd_valid_o,
	output logic [mcoc_pkg::DATA_W-1:0] rd_data_o
);

	logic [mcoc_pkg::BLK_W-1:0]  blk;	// Block code of the address
	mcoc_pkg::bus_req_t          req_d;
	mcoc_pkg::bus_req_t          req_q;
	mcoc_pkg::blk_sel_t          sel_d;
	mcoc_pkg::blk_sel_t          sel_q;
	logic                        idrg_d;	// Identification block hit
	logic                        idrg_q;
	logic [mcoc_pkg::DATA_W-1:0] id_word;
	logic [mcoc_pkg::DATA_W-1:0] rd_or;	// All read words combined
	logic                        rd_valid_q;
	logic [mcoc_pkg::DATA_W-1:0] rd_data_q;

	assign blk = bus_addr_i[mcoc_pkg::ADDR_W-1:mcoc_pkg::OFS_W];

	always_comb begin
		req_d.wr    = bus_stb_i & bus_wr_i;
		req_d.rd    = bus_stb_i & ~bus_wr_i;
		req_d.ofs   = bus_addr_i[mcoc_pkg::OFS_W-1:0];
		req_d.wdata = bus_wdata_i;
		sel_d.port  = bus_stb_i & (blk == mcoc_pkg::BLK_PORT);	// Block decode
		sel_d.tim0  = bus_stb_i & (blk == mcoc_pkg::BLK_TIM0);
		sel_d.tim1  = bus_stb_i & (blk == mcoc_pkg::BLK_TIM1);
		sel_d.intc  = bus_stb_i & (blk == mcoc_pkg::BLK_INTC);
		idrg_d      = bus_stb_i & (blk == mcoc_pkg::BLK_IDRG);
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			req_q  <= '0;
			sel_q  <= '0;
			idrg_q <= 1'b0;
		end else begin
			req_q  <= req_d;	// Request stage
			sel_q  <= sel_d;
			idrg_q <= idrg_d;
		end
	end

	// Read-only identification words
	always_comb begin
		id_word = '0;
		if (idrg_q && req_q.rd) begin
			case (req_q.ofs)
				4'h0:    id_word = mcoc_pkg::ID_CODE;
				4'h1:    id_word = mcoc_pkg::VERSION;
				4'h2:    id_word = mcoc_pkg::EDITION;
				default: id_word = '0;
			endcase
		end
	end

	assign rd_or = id_word | rd_port_i | rd_tim0_i | rd_tim1_i | rd_intc_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= req_q.rd;	// Also for unmapped reads
		end
	end

	always_ff @(posedge clk) begin
		rd_data_q <= rd_or;	// Response stage
	end

	assign req_o      = req_q;
	assign sel_o      = sel_q;
	assign rd_valid_o = rd_valid_q;
	assign rd_data_o  = rd_data_q;

endmodule

//--- logic/gpio_port.sv
`timescale 1ns/10ps

module gpio_port (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  mcoc_pkg::bus_req_t          req_i,	// Registered request
	input  logic                        sel_i,	// Port is addressed
	output logic [mcoc_pkg::DATA_W-1:0] rd_data_o,
	input  logic [15:0]                 port_pins_i,	// Pad inputs
	output logic [7:0]                  port_out_o,	// Pad output data
	output logic [7:0]                  port_oe_o	// Pad drive enable
);

	logic [7:0] data_q;	// Output data register
	logic [7:0] enb_q;	// Output enable register
	logic [7:0] sel_q;	// Input select register
	logic [7:0] pin_in;	// Muxed inputs
	logic       wr_en;

	assign wr_en = sel_i & req_i.wr;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			data_q <= '0;
			enb_q  <= '0;	// Pads undriven after reset
			sel_q  <= '0;
		end else if (wr_en) begin
			case (req_i.ofs)
				mcoc_pkg::PORT_DATA: data_q <= req_i.wdata[7:0];
				mcoc_pkg::PORT_ENB:  enb_q  <= req_i.wdata[7:0];
				mcoc_pkg::PORT_SEL:  sel_q  <= req_i.wdata[7:0];
				default: ;	// PIN is read only
			endcase
		end
	end

	// Pin k when select bit set, else pin k+8
	assign pin_in = (sel_q & port_pins_i[7:0]) | (~sel_q & port_pins_i[15:8]);

	always_comb begin
		rd_data_o = '0;
		if (sel_i && req_i.rd) begin
			case (req_i.ofs)
				mcoc_pkg::PORT_DATA: rd_data_o[7:0] = data_q;
				mcoc_pkg::PORT_ENB:  rd_data_o[7:0] = enb_q;
				mcoc_pkg::PORT_SEL:  rd_data_o[7:0] = sel_q;
				mcoc_pkg::PORT_PIN:  rd_data_o[7:0] = pin_in;	// Live pins
				default:             rd_data_o      = '0;
			endcase
		end
	end

	assign port_out_o = data_q;
	assign port_oe_o  = enb_q;

endmodule

//--- logic/irq_ctrl.sv
`timescale 1ns/10ps

module irq_ctrl (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  mcoc_pkg::bus_req_t          req_i,	// Registered request
	input  logic                        sel_i,	// Controller is addressed
	output logic [mcoc_pkg::DATA_W-1:0] rd_data_o,
	input  logic [1:0]                  ext_int_i,	// Asynchronous pins
	input  mcoc_pkg::tim_evt_t          tim0_evt_i,
	input  mcoc_pkg::tim_evt_t          tim1_evt_i,
	output logic                        irq_o
);

	logic [1:0]                 ext_s1_q;	// First sync stage
	logic [1:0]                 ext_s2_q;	// Second sync stage
	logic [1:0]                 ext_d_q;	// Edge register
	logic [mcoc_pkg::N_IRQ-1:0] src;	// Set requests this cycle
	logic [mcoc_pkg::N_IRQ-1:0] clr;	// Write one to clear
	logic [mcoc_pkg::N_IRQ-1:0] pend_q;
	logic [mcoc_pkg::N_IRQ-1:0] mask_q;
	logic [mcoc_pkg::N_IRQ-1:0] act;	// Pending and enabled
	logic [3:0]                 vec;
	logic                       wr_en;

	assign wr_en = sel_i & req_i.wr;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ext_s1_q <= '0;
			ext_s2_q <= '0;
			ext_d_q  <= '0;
		end else begin
			ext_s1_q <= ext_int_i;
			ext_s2_q <= ext_s1_q;
			ext_d_q  <= ext_s2_q;
		end
	end

	always_comb begin
		src = '0;
		src[mcoc_pkg::IRQ_INT0]      = ext_s2_q[0] & ~ext_d_q[0];	// Rising edge
		src[mcoc_pkg::IRQ_INT1]      = ext_s2_q[1] & ~ext_d_q[1];
		src[mcoc_pkg::IRQ_TIM0 +: 3] = tim0_evt_i;
		src[mcoc_pkg::IRQ_TIM1 +: 3] = tim1_evt_i;
	end

	assign clr = (wr_en && req_i.ofs == mcoc_pkg::INTC_PEND) ?
		req_i.wdata[mcoc_pkg::N_IRQ-1:0] : '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_q <= '0;
			mask_q <= '0;	// All sources off
		end else begin
			pend_q <= (pend_q & ~clr) | src;	// New event beats clear
			if (wr_en && req_i.ofs == mcoc_pkg::INTC_MASK) begin
				mask_q <= req_i.wdata[mcoc_pkg::N_IRQ-1:0];
			end
		end
	end

	assign act = pend_q & mask_q;

	// Lowest numbered active source wins
	always_comb begin
		vec = 4'(mcoc_pkg::N_IRQ);	// None active
		for (int i = mcoc_pkg::N_IRQ - 1; i >= 0; i--) begin
			if (act[i]) begin
				vec = 4'(i);
			end
		end
	end

	always_comb begin
		rd_data_o = '0;
		if (sel_i && req_i.rd) begin
			case (req_i.ofs)
				mcoc_pkg::INTC_PEND: rd_data_o[mcoc_pkg::N_IRQ-1:0] = pend_q;
				mcoc_pkg::INTC_MASK: rd_data_o[mcoc_pkg::N_IRQ-1:0] = mask_q;
				mcoc_pkg::INTC_VEC:  rd_data_o[3:0] = vec;
				default:             rd_data_o = '0;
			endcase
		end
	end

	assign irq_o = |act;

endmodule

//--- logic/mcoc_pkg.sv
package mcoc_pkg;

	localparam int DATA_W = 16;	// Bus data width
	localparam int ADDR_W = 16;	// Bus address width
	localparam int OFS_W  = 4;	// Register offset inside a block
	localparam int BLK_W  = ADDR_W - OFS_W;	// Block code width
	localparam int N_IRQ  = 8;	// Interrupt sources

	// Block codes on address bits 15..4
	localparam logic [BLK_W-1:0] BLK_IDRG = 12'h500;	// Identification
	localparam logic [BLK_W-1:0] BLK_PORT = 12'h501;
	localparam logic [BLK_W-1:0] BLK_TIM0 = 12'h502;
	localparam logic [BLK_W-1:0] BLK_TIM1 = 12'h503;
	localparam logic [BLK_W-1:0] BLK_INTC = 12'h504;

	localparam logic [DATA_W-1:0] ID_CODE = 16'h1150;	// Chip code
	localparam logic [DATA_W-1:0] VERSION = 16'h0148;	// Version 1.48
	localparam logic [DATA_W-1:0] EDITION = "TW";	// Two ASCII characters

	localparam logic [OFS_W-1:0] TIM_CTRL   = 4'h0;	// Bit 0 enables counting
	localparam logic [OFS_W-1:0] TIM_PERIOD = 4'h1;
	localparam logic [OFS_W-1:0] TIM_CMPA   = 4'h2;
	localparam logic [OFS_W-1:0] TIM_CMPB   = 4'h3;
	localparam logic [OFS_W-1:0] TIM_COUNT  = 4'h4;	// Read only

	localparam logic [OFS_W-1:0] PORT_DATA = 4'h0;	// Output data
	localparam logic [OFS_W-1:0] PORT_ENB  = 4'h1;	// Output enable
	localparam logic [OFS_W-1:0] PORT_SEL  = 4'h2;	// Input select
	localparam logic [OFS_W-1:0] PORT_PIN  = 4'h3;	// Muxed pin inputs

	localparam logic [OFS_W-1:0] INTC_PEND = 4'h0;	// Write one to clear
	localparam logic [OFS_W-1:0] INTC_MASK = 4'h1;
	localparam logic [OFS_W-1:0] INTC_VEC  = 4'h2;	// Lowest active source

	// Interrupt source positions
	localparam int IRQ_INT0 = 0;
	localparam int IRQ_INT1 = 1;
	localparam int IRQ_TIM0 = 2;	// ovf, cma, cmb upward
	localparam int IRQ_TIM1 = 5;

	typedef struct packed {
		logic              wr;	// Write request
		logic              rd;	// Read request
		logic [OFS_W-1:0]  ofs;	// Register offset
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic port;
		logic tim0;
		logic tim1;
		logic intc;
	} blk_sel_t;

	// ovf sits in bit 0 so the struct maps straight onto the source order
	typedef struct packed {
		logic cmb;	// Count hit CMPB
		logic cma;	// Count hit CMPA
		logic ovf;	// Count wrapped at period
	} tim_evt_t;

endpackage

//--- logic/mcoc_top.sv
`timescale 1ns/10ps

module mcoc_top #(
	parameter int CNT_W = mcoc_pkg::DATA_W	// Timer width
) (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        bus_stb_i,	// Request strobe
	input  logic                        bus_wr_i,
	input  logic [mcoc_pkg::ADDR_W-1:0] bus_addr_i,
	input  logic [mcoc_pkg::DATA_W-1:0] bus_wdata_i,
	output logic                        rd_valid_o,	// Two cycles after strobe
	output logic [mcoc_pkg::DATA_W-1:0] rd_data_o,
	input  logic [15:0]                 port_pins_i,
	output logic [7:0]                  port_out_o,
	output logic [7:0]                  port_oe_o,
	input  logic [1:0]                  ext_int_i,	// int1, int0
	output logic                        tim0_pwma_o,
	output logic                        tim0_pwmb_o,
	output logic                        tim1_pwma_o,
	output logic                        tim1_pwmb_o,
	output logic                        irq_o
);

	mcoc_pkg::bus_req_t          req;	// Shared registered request
	mcoc_pkg::blk_sel_t          sel;
	logic [mcoc_pkg::DATA_W-1:0] rd_port;
	logic [mcoc_pkg::DATA_W-1:0] rd_tim0;
	logic [mcoc_pkg::DATA_W-1:0] rd_tim1;
	logic [mcoc_pkg::DATA_W-1:0] rd_intc;
	mcoc_pkg::tim_evt_t          tim0_evt;
	mcoc_pkg::tim_evt_t          tim1_evt;

	bus_ctrl bus_ctrl_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.bus_stb_i   (bus_stb_i),
		.bus_wr_i    (bus_wr_i),
		.bus_addr_i  (bus_addr_i),
		.bus_wdata_i (bus_wdata_i),
		.rd_port_i   (rd_port),
		.rd_tim0_i   (rd_tim0),
		.rd_tim1_i   (rd_tim1),
		.rd_intc_i   (rd_intc),
		.req_o       (req),
		.sel_o       (sel),
		.rd_valid_o  (rd_valid_o),
		.rd_data_o   (rd_data_o)
	);

	gpio_port gpio_port_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_i       (req),
		.sel_i       (sel.port),
		.rd_data_o   (rd_port),
		.port_pins_i (port_pins_i),
		.port_out_o  (port_out_o),
		.port_oe_o   (port_oe_o)
	);

	pwm_timer #(.CNT_W(CNT_W)) tim0_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.req_i     (req),
		.sel_i     (sel.tim0),
		.rd_data_o (rd_tim0),
		.pwma_o    (tim0_pwma_o),
		.pwmb_o    (tim0_pwmb_o),
		.evt_o     (tim0_evt)
	);

	pwm_timer #(.CNT_W(CNT_W)) tim1_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.req_i     (req),
		.sel_i     (sel.tim1),
		.rd_data_o (rd_tim1),
		.pwma_o    (tim1_pwma_o),
		.pwmb_o    (tim1_pwmb_o),
		.evt_o     (tim1_evt)
	);

	irq_ctrl irq_ctrl_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_i      (req),
		.sel_i      (sel.intc),
		.rd_data_o  (rd_intc),
		.ext_int_i  (ext_int_i),
		.tim0_evt_i (tim0_evt),
		.tim1_evt_i (tim1_evt),
		.irq_o      (irq_o)
	);

endmodule

//--- logic/pwm_timer.sv
`timescale 1ns/10ps

module pwm_timer #(
	parameter int CNT_W = 16	// Counter and compare width
) (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  mcoc_pkg::bus_req_t          req_i,	// Registered request
	input  logic                        sel_i,	// This timer is addressed
	output logic [mcoc_pkg::DATA_W-1:0] rd_data_o,
	output logic                        pwma_o,
	output logic                        pwmb_o,
	output mcoc_pkg::tim_evt_t          evt_o	// One cycle pulses
);

	logic               en_q;	// CTRL bit 0
	logic [CNT_W-1:0]   period_q;	// Last count before wrap
	logic [CNT_W-1:0]   cmpa_q;
	logic [CNT_W-1:0]   cmpb_q;
	logic [CNT_W-1:0]   cnt_q;
	logic               wr_en;
	logic               at_top;	// Count equals period
	mcoc_pkg::tim_evt_t evt_q;

	assign wr_en  = sel_i & req_i.wr;
	assign at_top = (cnt_q == period_q);

	// Register writes
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			en_q     <= 1'b0;
			period_q <= '0;
			cmpa_q   <= '0;	// Keeps PWM low out of reset
			cmpb_q   <= '0;
		end else if (wr_en) begin
			case (req_i.ofs)
				mcoc_pkg::TIM_CTRL:   en_q     <= req_i.wdata[0];
				mcoc_pkg::TIM_PERIOD: period_q <= req_i.wdata[CNT_W-1:0];
				mcoc_pkg::TIM_CMPA:   cmpa_q   <= req_i.wdata[CNT_W-1:0];
				mcoc_pkg::TIM_CMPB:   cmpb_q   <= req_i.wdata[CNT_W-1:0];
				default: ;	// COUNT is read only
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (!en_q) begin
			cnt_q <= '0;	// Held at zero while stopped
		end else if (at_top) begin
			cnt_q <= '0;	// Wrap
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			evt_q <= '0;
		end else begin
			evt_q.ovf <= en_q & at_top;
			evt_q.cma <= en_q & (cnt_q == cmpa_q);
			evt_q.cmb <= en_q & (cnt_q == cmpb_q);
		end
	end

	// Read mux stays zero when not addressed
	always_comb begin
		rd_data_o = '0;
		if (sel_i && req_i.rd) begin
			case (req_i.ofs)
				mcoc_pkg::TIM_CTRL:   rd_data_o[0]         = en_q;
				mcoc_pkg::TIM_PERIOD: rd_data_o[CNT_W-1:0] = period_q;
				mcoc_pkg::TIM_CMPA:   rd_data_o[CNT_W-1:0] = cmpa_q;
				mcoc_pkg::TIM_CMPB:   rd_data_o[CNT_W-1:0] = cmpb_q;
				mcoc_pkg::TIM_COUNT:  rd_data_o[CNT_W-1:0] = cnt_q;
				default:              rd_data_o            = '0;
			endcase
		end
	end

	assign pwma_o = en_q & (cnt_q < cmpa_q);	// Duty of CMPA counts
	assign pwmb_o = en_q & (cnt_q < cmpb_q);
	assign evt_o  = evt_q;

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_mcoc -f tb.f -o tb_mcoc_sim || {
	echo "Verilator build failed"
	exit 1
}

out=$(./obj_dir/tb_mcoc_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "^Simulation PASSED$" && exit 0 || exit 1

//--- tb.f
logic/mcoc_pkg.sv
logic/bus_ctrl.sv
logic/pwm_timer.sv
logic/gpio_port.sv
logic/irq_ctrl.sv
logic/mcoc_top.sv
dv/tb_mcoc.sv
